// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module apbI2cTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sources.f
verilog/apbI2cRegPkg.sv
verilog/i2cFramePkg.sv
verilog/syncFifo.sv
verilog/apbSlave.sv
verilog/i2cMaster.sv
verilog/apbI2cTop.sv
tb/clockGen.sv
tb/i2cSlaveModel.sv
tb/apbI2cTb.sv

// File: tb/apbI2cTb.sv
/* Testbench of the APB to I2C bridge. Expects a slave model at 7'h50 and
   runs six directed tests with LFSR data, stops on any timeout */
`default_nettype none
`timescale 1ns/10ps

module apbI2cTb;

	wire         PCLK;
	wire         PRESETn;
	logic        PSELx;
	logic        PENABLE;
	logic        PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	wire  [31:0] PRDATA;
	wire         PREADY;
	wire         PSLVERR;
	wire         intTx;
	wire         intRx;
	wire         sclOe;
	wire         sdaOe;
	wire         slvPull;
	// Open drain lines, low when any side pulls
	wire         sclLine = !sclOe;
	wire         sdaLine = !(sdaOe || slvPull);

	logic [31:0]        lfsr;
	logic [31:0]        rd;
	logic [31:0]        v;
	logic               err;
	logic [7:0]         lastByte;
	logic [7:0]         wrBytes [$];
	logic [31:0]        gotQ [$];
	logic [31:0]        expQ [$];
	string              msgQ [$];
	i2cFramePkg::txWord hw;
	int                 cnt;
	int                 n;
	int                 checks;
	int                 errors;
	int                 testErrs;
	int                 testsRun;
	int                 testsBad;

	clockGen clk (.PCLK(PCLK), .PRESETn(PRESETn));

	apbI2cTop dut (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.intTx(intTx), .intRx(intRx), .sclOe(sclOe), .sdaOe(sdaOe),
		.sclIn(sclLine), .sdaIn(sdaLine)
	);

	i2cSlaveModel slave (.scl(sclLine), .sda(sdaLine), .sdaPull(slvPull));

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One step per bit taken
	task automatic randBits(input int bits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < bits; i++)
		begin
			val  = {val[30:0], lfsr[0]};
			lfsr = galoisStep(lfsr);
		end
	endtask

	// Slave read pattern
	function automatic logic [31:0] expectedRead(input logic [7:0] idx, input logic [7:0] last);
		return {24'h0, (8'hA5 ^ idx) + last};
	endfunction

	task automatic die(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$finish;
	endtask

	// Setup, access, sample at the falling edge, release
	task automatic apbXfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic slverr);
		int waits;
		waits = 0;
		@(posedge PCLK);
		PSELx   <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= wr;
		PADDR   <= addr;
		PWDATA  <= data;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		@(negedge PCLK);
		while (!PREADY)
		begin
			waits++;
			if (waits > 16)
				die("Timeout: PREADY never came in the APB access phase");
			@(negedge PCLK);
		end
		rdata  = PRDATA;
		slverr = PSLVERR;
		@(posedge PCLK);
		PSELx   <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, output logic slverr);
		logic [31:0] dummy;
		apbXfer(1'b1, addr, data, dummy, slverr);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data, output logic slverr);
		apbXfer(1'b0, addr, 32'h0, data, slverr);
	endtask

	task automatic expectValue(input logic [31:0] got, input logic [31:0] exp, input string msg);
		gotQ.push_back(got);
		expQ.push_back(exp);
		msgQ.push_back(msg);
	endtask

	// Poll status until the engine is idle with the transmit FIFO drained
	task automatic waitFrameDone();
		logic [31:0] st;
		logic        e;
		int          polls;
		polls = 0;
		apbRead(apbI2cRegPkg::statusAddr, st, e);
		while (st[apbI2cRegPkg::stBusyBit] || !st[apbI2cRegPkg::stTxEmptyBit])
		begin
			polls++;
			if (polls > 2000)
				die("Timeout: engine stayed busy, the I2C frame did not finish");
			apbRead(apbI2cRegPkg::statusAddr, st, e);
		end
	endtask

	task automatic finishTest(input string name);
		int waits;
		waits = 0;
		while (gotQ.size() > 0)
		begin
			waits++;
			if (waits > 100)
				die("Timeout: checker queue did not drain");
			@(posedge PCLK);
		end
		testsRun++;
		if (testErrs == 0)
			$display("Test %0d %s: ok", testsRun, name);
		else
		begin
			$display("Test %0d %s: %0d errors", testsRun, name, testErrs);
			testsBad++;
		end
		testErrs = 0;
	endtask

	// Checker
	always @(negedge PCLK)
	begin
		while (gotQ.size() > 0)
		begin
			checks++;
			assert (gotQ[0] === expQ[0])
			else
			begin
				$display("[FAIL] %0t: %s, got %h expected %h", $time, msgQ[0], gotQ[0], expQ[0]);
				errors++;
				testErrs++;
			end
			void'(gotQ.pop_front());
			void'(expQ.pop_front());
			void'(msgQ.pop_front());
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		PSELx    = 1'b0;
		PENABLE  = 1'b0;
		PWRITE   = 1'b0;
		PADDR    = '0;
		PWDATA   = '0;
		lfsr     = 32'h1114_93d1;
		lastByte = 8'h00;
		checks   = 0;
		errors   = 0;
		testErrs = 0;
		testsRun = 0;
		testsBad = 0;
		n        = 0;
		while (PRESETn !== 1'b1)
		begin
			n++;
			if (n > 50)
				die("Timeout: reset was never released");
			@(posedge PCLK);
		end

		// Reset values and register read back
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue(rd, 32'h3, "status after reset");
		@(negedge PCLK);
		expectValue({30'h0, intTx, intRx}, 32'h2, "interrupts after reset");
		apbRead(apbI2cRegPkg::configAddr, rd, err);
		expectValue(rd, 32'h0, "config after reset");
		apbRead(apbI2cRegPkg::timeoutAddr, rd, err);
		expectValue(rd, 32'h0, "timeout after reset");
		randBits(32, v);
		apbWrite(apbI2cRegPkg::configAddr, v, err);
		apbRead(apbI2cRegPkg::configAddr, rd, err);
		expectValue(rd, {18'h0, v[13:0]}, "config read back");
		randBits(32, v);
		apbWrite(apbI2cRegPkg::timeoutAddr, v, err);
		apbRead(apbI2cRegPkg::timeoutAddr, rd, err);
		expectValue(rd, {18'h0, v[13:0]}, "timeout read back");
		finishTest("reset and registers");

		// Write frame, enable with half period of 4
		apbWrite(apbI2cRegPkg::configAddr, 32'h104, err);
		apbWrite(apbI2cRegPkg::timeoutAddr, 32'h0, err);
		randBits(2, v);
		cnt = 2 + v;
		hw = '0;
		hw.hdr.addr  = 7'h50;
		hw.hdr.rd    = 1'b0;
		hw.hdr.count = cnt[7:0];
		apbWrite(apbI2cRegPkg::txDataAddr, hw, err);
		expectValue({31'h0, err}, 32'h0, "write header PSLVERR");
		wrBytes.delete();
		for (int i = 0; i < cnt; i++)
		begin
			randBits(8, v);
			wrBytes.push_back(v[7:0]);
			apbWrite(apbI2cRegPkg::txDataAddr, {24'h0, v[7:0]}, err);
			expectValue({31'h0, err}, 32'h0, "write data PSLVERR");
		end
		waitFrameDone();
		expectValue(slave.rxCount, cnt, "bytes stored by slave");
		for (int i = 0; i < cnt; i++)
			expectValue({24'h0, slave.rxMem[i]}, {24'h0, wrBytes[i]}, "byte stored by slave");
		lastByte = wrBytes[cnt - 1];
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue(rd & 32'h18, 32'h0, "error bits after write frame");
		finishTest("write frame");

		// Read frame into the receive FIFO
		randBits(2, v);
		cnt = 2 + v;
		hw = '0;
		hw.hdr.addr  = 7'h50;
		hw.hdr.rd    = 1'b1;
		hw.hdr.count = cnt[7:0];
		apbWrite(apbI2cRegPkg::txDataAddr, hw, err);
		waitFrameDone();
		@(negedge PCLK);
		expectValue({31'h0, intRx}, 32'h1, "intRx with data waiting");
		for (int i = 0; i < cnt; i++)
		begin
			apbRead(apbI2cRegPkg::rxDataAddr, rd, err);
			expectValue(rd, expectedRead(i[7:0], lastByte), "read byte");
		end
		@(negedge PCLK);
		expectValue({31'h0, intRx}, 32'h0, "intRx after last pop");
		finishTest("read frame");

		// No slave at 7'h23
		hw = '0;
		hw.hdr.addr  = 7'h23;
		hw.hdr.count = 8'd1;
		apbWrite(apbI2cRegPkg::txDataAddr, hw, err);
		apbWrite(apbI2cRegPkg::txDataAddr, 32'h3C, err);
		waitFrameDone();
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue({31'h0, err}, 32'h1, "PSLVERR with error set");
		expectValue(rd & 32'h18, 32'h18, "nack and error bits");
		apbWrite(apbI2cRegPkg::statusAddr, 32'h0, err);
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue(rd, 32'h3, "status after clear");
		expectValue({31'h0, err}, 32'h0, "PSLVERR after clear");
		finishTest("address NACK");

		// Header asks for 3 bytes, only one supplied
		apbWrite(apbI2cRegPkg::timeoutAddr, 32'd40, err);
		hw = '0;
		hw.hdr.addr  = 7'h50;
		hw.hdr.count = 8'd3;
		apbWrite(apbI2cRegPkg::txDataAddr, hw, err);
		apbWrite(apbI2cRegPkg::txDataAddr, 32'h77, err);
		waitFrameDone();
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue(rd & 32'h18, 32'h08, "error without nack after timeout");
		@(negedge PCLK);
		expectValue({30'h0, sclOe, sdaOe}, 32'h0, "bus released after timeout");
		apbWrite(apbI2cRegPkg::statusAddr, 32'h0, err);
		apbRead(apbI2cRegPkg::statusAddr, rd, err);
		expectValue(rd, 32'h3, "status after clear");
		finishTest("transmit timeout");

		// Overfill with the engine off, then an unmapped offset
		apbWrite(apbI2cRegPkg::configAddr, 32'h0, err);
		for (int i = 0; i <= i2cFramePkg::fifoDepth; i++)
		begin
			apbWrite(apbI2cRegPkg::txDataAddr, i, err);
			expectValue({31'h0, err}, {31'h0, i == i2cFramePkg::fifoDepth}, "push PSLVERR");
		end
		@(negedge PCLK);
		expectValue({31'h0, intTx}, 32'h0, "intTx with words queued");
		apbRead(32'h20, rd, err);
		expectValue({31'h0, err}, 32'h1, "unmapped PSLVERR");
		finishTest("FIFO full and unmapped");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsBad, checks,
			errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/clockGen.sv
/* Testbench clock and reset. PCLK period is 10 ns and PRESETn is held
   low for the first 5 rising edges */
`default_nettype none
`timescale 1ns/10ps

module clockGen (
	output logic PCLK,
	output logic PRESETn
);

	initial
	begin
		PCLK    = 1'b0;
		PRESETn = 1'b0;
		// Reset released on the fifth edge
		repeat (5) @(posedge PCLK);
		PRESETn <= 1'b1;
	end

	always #5 PCLK = ~PCLK;

endmodule

`default_nettype wire

// File: tb/i2cSlaveModel.sv
/* Behavioral I2C slave, no clock stretching. Stores written bytes and answers
   reads with (8'hA5 ^ index) + last written byte */
`default_nettype none
`timescale 1ns/10ps

module i2cSlaveModel #(
	parameter logic [6:0] devAddr = 7'h50
) (
	input  wire  scl,
	input  wire  sda,
	output logic sdaPull
);

	logic       active;
	logic       addrPhase;
	logic       matched;
	logic       isRead;
	logic       ackNext;
	logic [7:0] shift;
	logic [7:0] outByte;
	logic [7:0] lastWritten;
	logic [7:0] rxMem [256];
	int         bitIdx;
	int         readIdx;
	int         rxCount;

	initial
	begin
		sdaPull     = 1'b0;
		active      = 1'b0;
		addrPhase   = 1'b0;
		matched     = 1'b0;
		isRead      = 1'b0;
		ackNext     = 1'b0;
		lastWritten = 8'h00;
		bitIdx      = 0;
		readIdx     = 0;
		rxCount     = 0;
	end

	// START, SDA falls with SCL high
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active    = 1'b1;
			addrPhase = 1'b1;
			matched   = 1'b0;
			bitIdx    = 0;
			sdaPull   = 1'b0;
		end
	end

	// STOP, SDA rises with SCL high
	always @(posedge sda)
	begin
		if (scl === 1'b1 && active)
		begin
			active  = 1'b0;
			sdaPull = 1'b0;
		end
	end

	// Sample on the rising clock
	always @(posedge scl)
	begin
		if (active && bitIdx < 8)
		begin
			shift  = {shift[6:0], sda};
			bitIdx = bitIdx + 1;
			if (bitIdx == 8 && addrPhase)
			begin
				matched = (shift[7:1] == devAddr);
				isRead  = shift[0];
				readIdx = 0;
				if (matched && !isRead)
					rxCount = 0;
				ackNext = matched;
			end
			else if (bitIdx == 8 && matched && !isRead)
			begin
				rxMem[rxCount] = shift;
				rxCount        = rxCount + 1;
				lastWritten    = shift;
				ackNext        = 1'b1;
			end
			else if (bitIdx == 8)
				ackNext = 1'b0;
		end
		else if (active)
		begin
			// ACK slot, a NACK from the master ends the read
			if (!addrPhase && matched && isRead)
			begin
				readIdx = readIdx + 1;
				if (sda)
					matched = 1'b0;
			end
			addrPhase = 1'b0;
			bitIdx    = 0;
		end
	end

	// Drive SDA for the next bit while SCL is low
	always @(negedge scl)
	begin
		if (active)
		begin
			outByte = (8'hA5 ^ readIdx[7:0]) + lastWritten;
			if (bitIdx == 8)
				sdaPull = ackNext;
			else if (!addrPhase && matched && isRead)
				sdaPull = !outByte[7 - bitIdx];
			else
				sdaPull = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/apbI2cRegPkg.sv
/* APB register map of the I2C bridge. Offsets are byte addresses and both
   control registers are 14 bits wide. A divider below 2 runs as 2 */
`default_nettype none

package apbI2cRegPkg;

	////////////////////////////////////////////////////////////////////////////
	// Register offsets
	////////////////////////////////////////////////////////////////////////////

	// Write pushes the transmit FIFO
	localparam logic [31:0] txDataAddr  = 32'h0000_0000;
	// Read pops the receive FIFO
	localparam logic [31:0] rxDataAddr  = 32'h0000_0004;
	localparam logic [31:0] configAddr  = 32'h0000_0008;
	localparam logic [31:0] timeoutAddr = 32'h0000_000C;
	// Read gives flags, any write clears the sticky error
	localparam logic [31:0] statusAddr  = 32'h0000_0010;

	// Width of configuration and timeout registers
	localparam int regWidth = 14;

	// Configuration fields
	localparam int cfgDivLsb    = 0;
	localparam int cfgDivWidth  = 8;
	localparam int cfgEnableBit = 8;

	// Status word bits
	localparam int stTxEmptyBit = 0;
	localparam int stRxEmptyBit = 1;
	localparam int stBusyBit    = 2;
	localparam int stErrorBit   = 3;
	localparam int stNackBit    = 4;

endpackage

`default_nettype wire

// File: verilog/apbI2cTop.sv
/* APB to I2C bridge top. SCL and SDA are open drain, the Oe outputs pull the
   line low and the pads are resolved outside */
`default_nettype none
`timescale 1ns/10ps

module apbI2cTop (
	input  wire         PCLK,
	input  wire         PRESETn,
	input  wire         PSELx,
	input  wire         PENABLE,
	input  wire         PWRITE,
	input  wire  [31:0] PADDR,
	input  wire  [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	output logic        intTx,
	output logic        intRx,
	output logic        sclOe,
	output logic        sdaOe,
	input  wire         sclIn,
	input  wire         sdaIn
);

	// Transmit path
	logic                              txPush;
	logic [31:0]                       txData;
	logic                              txPop;
	logic                              txFull;
	logic                              txEmpty;
	i2cFramePkg::txWord                txHead;
	// Receive path
	logic                              rxPush;
	logic [i2cFramePkg::byteWidth-1:0] rxByte;
	logic                              rxPop;
	logic [31:0]                       rxData;
	logic                              rxFull;
	logic                              rxEmpty;
	// Control and status
	logic [apbI2cRegPkg::regWidth-1:0] cfgReg;
	logic [apbI2cRegPkg::regWidth-1:0] timeoutReg;
	logic                              errClear;
	logic                              busy;
	logic                              error;
	logic                              nack;

	apbSlave slave (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.txFull(txFull), .rxData(rxData), .rxEmpty(rxEmpty), .txEmpty(txEmpty), .busy(busy),
		.error(error), .nack(nack), .txPush(txPush), .txData(txData), .rxPop(rxPop),
		.cfgReg(cfgReg), .timeoutReg(timeoutReg), .errClear(errClear),
		.intTx(intTx), .intRx(intRx)
	);

	// APB writes in, engine pops headers and data
	syncFifo txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pushData(txData),
		.pop(txPop), .popData(txHead), .full(txFull), .empty(txEmpty)
	);

	// Received bytes zero extended to a word
	syncFifo rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush),
		.pushData({{(i2cFramePkg::wordWidth - i2cFramePkg::byteWidth){1'b0}}, rxByte}),
		.pop(rxPop), .popData(rxData), .full(rxFull), .empty(rxEmpty)
	);

	i2cMaster engine (
		.PCLK(PCLK), .PRESETn(PRESETn), .cfgReg(cfgReg), .timeoutReg(timeoutReg),
		.errClear(errClear), .txData(txHead), .txEmpty(txEmpty), .rxFull(rxFull),
		.sclIn(sclIn), .sdaIn(sdaIn), .txPop(txPop), .rxPush(rxPush), .rxByte(rxByte),
		.busy(busy), .error(error), .nack(nack), .sclOe(sclOe), .sdaOe(sdaOe)
	);

endmodule

`default_nettype wire

// File: verilog/apbSlave.sv
/* Zero wait state APB slave. Unmapped offsets, writes to a full transmit FIFO
   and any access while the engine error is set answer with PSLVERR */
`default_nettype none
`timescale 1ns/10ps

module apbSlave (
	input  wire                                    PCLK,
	input  wire                                    PRESETn,
	input  wire                                    PSELx,
	input  wire                                    PENABLE,
	input  wire                                    PWRITE,
	input  wire  [31:0]                            PADDR,
	input  wire  [31:0]                            PWDATA,
	output logic [31:0]                            PRDATA,
	output logic                                   PREADY,
	output logic                                   PSLVERR,
	input  wire                                    txFull,
	input  wire  [31:0]                            rxData,
	input  wire                                    rxEmpty,
	input  wire                                    txEmpty,
	input  wire                                    busy,
	input  wire                                    error,
	input  wire                                    nack,
	output logic                                   txPush,
	output logic [31:0]                            txData,
	output logic                                   rxPop,
	output logic [apbI2cRegPkg::regWidth-1:0]      cfgReg,
	output logic [apbI2cRegPkg::regWidth-1:0]      timeoutReg,
	output logic                                   errClear,
	output logic                                   intTx,
	output logic                                   intRx
);

	logic        access;
	logic        wrAccess;
	logic        rdAccess;
	logic        mapped;
	logic        txFullWrite;
	logic [31:0] statusWord;

	// Access phase, setup phase is ignored
	assign access   = PSELx && PENABLE;
	assign wrAccess = access && PWRITE;
	assign rdAccess = access && !PWRITE;
	assign mapped   = (PADDR == apbI2cRegPkg::txDataAddr) || (PADDR == apbI2cRegPkg::rxDataAddr)
		|| (PADDR == apbI2cRegPkg::configAddr) || (PADDR == apbI2cRegPkg::timeoutAddr)
		|| (PADDR == apbI2cRegPkg::statusAddr);

	// No wait states on any offset
	assign PREADY = access;

	////////////////////////////////////////////////////////////////////////////
	// FIFO strobes
	////////////////////////////////////////////////////////////////////////////

	assign txData      = PWDATA;
	assign txPush      = wrAccess && (PADDR == apbI2cRegPkg::txDataAddr) && !txFull;
	// Dropped write, reported below
	assign txFullWrite = wrAccess && (PADDR == apbI2cRegPkg::txDataAddr) && txFull;
	// Pop in the same cycle the head is shown
	assign rxPop       = rdAccess && (PADDR == apbI2cRegPkg::rxDataAddr) && !rxEmpty;
	assign errClear    = wrAccess && (PADDR == apbI2cRegPkg::statusAddr);

	assign PSLVERR = access && (!mapped || error || txFullWrite);

	// Interrupts straight from FIFO flags
	assign intTx = txEmpty;
	assign intRx = !rxEmpty;

	always_comb
	begin
		statusWord = '0;
		statusWord[apbI2cRegPkg::stTxEmptyBit] = txEmpty;
		statusWord[apbI2cRegPkg::stRxEmptyBit] = rxEmpty;
		statusWord[apbI2cRegPkg::stBusyBit]    = busy;
		statusWord[apbI2cRegPkg::stErrorBit]   = error;
		statusWord[apbI2cRegPkg::stNackBit]    = nack;
	end

	// Read mux, zero outside read access
	always_comb
	begin
		PRDATA = '0;
		if (rdAccess)
		begin
			case (PADDR)
				apbI2cRegPkg::rxDataAddr:  PRDATA = rxEmpty ? '0 : rxData;
				apbI2cRegPkg::configAddr:  PRDATA = {{(32 - apbI2cRegPkg::regWidth){1'b0}}, cfgReg};
				apbI2cRegPkg::timeoutAddr:
					PRDATA = {{(32 - apbI2cRegPkg::regWidth){1'b0}}, timeoutReg};
				apbI2cRegPkg::statusAddr:  PRDATA = statusWord;
				default:                   PRDATA = '0;
			endcase
		end
	end

	// Control registers keep the low bits of the write
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg     <= '0;
			timeoutReg <= '0;
		end
		else if (wrAccess)
		begin
			if (PADDR == apbI2cRegPkg::configAddr)
				cfgReg <= PWDATA[apbI2cRegPkg::regWidth-1:0];
			if (PADDR == apbI2cRegPkg::timeoutAddr)
				timeoutReg <= PWDATA[apbI2cRegPkg::regWidth-1:0];
		end
	end

	// Ready only comes out of a proper setup phase
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		$rose(PREADY) |-> $past(PSELx && !PENABLE));
	// A push lands in the transmit FIFO on the next cycle
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		txPush |=> !txEmpty);

endmodule

`default_nettype wire

// File: verilog/i2cFramePkg.sv
/* Frame format of the transmit FIFO. The first word of a frame is a header
   and the words after it carry one data byte each in the low bits */
`default_nettype none

package i2cFramePkg;

	localparam int byteWidth     = 8;
	localparam int wordWidth     = 32;
	// FIFO depth in words, power of two
	localparam int fifoDepth     = 8;
	localparam int fifoAddrWidth = $clog2(fifoDepth);

	// Header view, count of 1 to 255 data bytes
	typedef struct packed {
		logic [wordWidth-2*byteWidth-1:0] rsvd;
		logic [byteWidth-1:0]             count;
		logic                             rd;
		logic [6:0]                       addr;
	} hdrFields;

	// Data view, one byte per word
	typedef struct packed {
		logic [wordWidth-byteWidth-1:0] rsvd;
		logic [byteWidth-1:0]           dataByte;
	} dataFields;

	typedef union packed {
		hdrFields  hdr;
		dataFields dat;
	} txWord;

endpackage

`default_nettype wire

// File: verilog/i2cMaster.sv
/* Single master I2C engine, 7-bit addresses, no clock stretching, no repeated
   START. Error is sticky until errClear and blocks new frames */
`default_nettype none
`timescale 1ns/10ps

module i2cMaster (
	input  wire                                  PCLK,
	input  wire                                  PRESETn,
	input  wire  [apbI2cRegPkg::regWidth-1:0]    cfgReg,
	input  wire  [apbI2cRegPkg::regWidth-1:0]    timeoutReg,
	input  wire                                  errClear,
	input  wire  i2cFramePkg::txWord             txData,
	input  wire                                  txEmpty,
	input  wire                                  rxFull,
	input  wire                                  sclIn,
	input  wire                                  sdaIn,
	output logic                                 txPop,
	output logic                                 rxPush,
	output logic [i2cFramePkg::byteWidth-1:0]    rxByte,
	output logic                                 busy,
	output logic                                 error,
	output logic                                 nack,
	output logic                                 sclOe,
	output logic                                 sdaOe
);

	typedef logic [apbI2cRegPkg::cfgDivWidth-1:0] divT;
	typedef logic [i2cFramePkg::byteWidth-1:0]    byteT;
	typedef logic [apbI2cRegPkg::regWidth-1:0]    regT;
	typedef enum logic [2:0] {sIdle, sStart, sByte, sNext, sStop, sDrain} frameState;

	frameState state;
	divT       cfgDiv;
	divT       divEff;
	divT       half;
	divT       divCnt;
	logic      tick;
	logic      mid;
	logic      enable;
	logic      sclPhase;
	logic [3:0] bitCnt;
	byteT      shReg;
	byteT      count;
	logic      rdFlag;
	logic      addrPhase;
	logic      txMode;
	regT       waitCnt;
	logic      startPop;
	logic      wrFetch;
	logic      rdStore;
	logic      drainPop;
	logic      waiting;
	logic      timedOut;

	////////////////////////////////////////////////////////////////////////////
	// Bit timing
	////////////////////////////////////////////////////////////////////////////

	assign enable = cfgReg[apbI2cRegPkg::cfgEnableBit];
	assign cfgDiv = cfgReg[apbI2cRegPkg::cfgDivLsb +: apbI2cRegPkg::cfgDivWidth];
	// Half SCL period, clamped to 2
	assign divEff = (cfgDiv < divT'(2)) ? divT'(2) : cfgDiv;
	assign half   = divEff >> 1;
	// Tick ends a half period, mid moves SDA inside it
	assign tick   = (divCnt == divEff - divT'(1));
	assign mid    = (divCnt == half - divT'(1));

	// Address byte and write data go out, read data comes in
	assign txMode = addrPhase || !rdFlag;

	////////////////////////////////////////////////////////////////////////////
	// FIFO handshakes
	////////////////////////////////////////////////////////////////////////////

	assign startPop = (state == sIdle) && enable && !error && !txEmpty;
	assign wrFetch  = (state == sNext) && !rdFlag && (count != '0) && !txEmpty;
	assign rdStore  = (state == sNext) && rdFlag && !addrPhase && !rxFull;
	assign drainPop = (state == sDrain) && (count != '0) && !txEmpty;
	assign txPop    = startPop || wrFetch || drainPop;
	assign rxPush   = rdStore;
	assign rxByte   = shReg;
	assign busy     = (state != sIdle);

	// Stalls with SCL held low, counted against the timeout
	assign waiting  = (state == sNext) && ((!rdFlag && (count != '0) && txEmpty)
		|| (rdFlag && !addrPhase && rxFull));
	assign timedOut = waiting && (timeoutReg != '0) && (waitCnt == timeoutReg);

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state     <= sIdle;
			sclPhase  <= 1'b0;
			divCnt    <= '0;
			bitCnt    <= '0;
			addrPhase <= 1'b0;
			waitCnt   <= '0;
			error     <= 1'b0;
			nack      <= 1'b0;
			sclOe     <= 1'b0;
			sdaOe     <= 1'b0;
		end
		else
		begin
			// Divider only runs while the bus is being clocked
			if (state == sStart || state == sByte || state == sStop)
				divCnt <= tick ? '0 : divCnt + divT'(1);
			else
				divCnt <= '0;
			waitCnt <= waiting ? waitCnt + regT'(1) : '0;
			if (errClear)
			begin
				error <= 1'b0;
				nack  <= 1'b0;
			end
			case (state)
				sIdle:
					// Header word starts a frame
					if (startPop)
					begin
						rdFlag    <= txData.hdr.rd;
						count     <= txData.hdr.count;
						shReg     <= {txData.hdr.addr, txData.hdr.rd};
						addrPhase <= 1'b1;
						state     <= sStart;
					end
				sStart:
				begin
					// SDA falls while SCL is high
					if (mid)
						sdaOe <= 1'b1;
					if (tick)
					begin
						sclOe    <= 1'b1;
						sclPhase <= 1'b0;
						bitCnt   <= '0;
						state    <= sByte;
					end
				end
				sByte:
				begin
					// Eight data bits then the ACK slot
					if (mid && !sclPhase)
					begin
						if (bitCnt < 4'd8)
							sdaOe <= txMode && !shReg[7];
						else
							sdaOe <= !txMode && (count != byteT'(1));
					end
					if (tick && !sclPhase)
					begin
						sclOe    <= 1'b0;
						sclPhase <= 1'b1;
					end
					else if (tick)
					begin
						sclOe    <= 1'b1;
						sclPhase <= 1'b0;
						if (bitCnt < 4'd8)
						begin
							shReg  <= {shReg[6:0], sdaIn};
							bitCnt <= bitCnt + 4'd1;
						end
						else if (txMode && sdaIn)
						begin
							// Ninth pulse sampled high, no ACK
							nack  <= 1'b1;
							error <= 1'b1;
							state <= sStop;
						end
						else
							state <= sNext;
					end
				end
				sNext:
				begin
					bitCnt <= '0;
					if (timedOut)
					begin
						error <= 1'b1;
						state <= sStop;
					end
					else if (rdFlag && addrPhase)
					begin
						addrPhase <= 1'b0;
						state     <= (count == '0) ? sStop : sByte;
					end
					else if (rdStore)
					begin
						count <= count - byteT'(1);
						state <= (count == byteT'(1)) ? sStop : sByte;
					end
					else if (!rdFlag && (count == '0))
					begin
						addrPhase <= 1'b0;
						state     <= sStop;
					end
					else if (wrFetch)
					begin
						addrPhase <= 1'b0;
						shReg     <= txData.dat.dataByte;
						count     <= count - byteT'(1);
						state     <= sByte;
					end
				end
				sStop:
				begin
					// Pull SDA in the low half, release it in the high half
					if (mid)
						sdaOe <= !sclPhase;
					if (tick && !sclPhase)
					begin
						sclOe    <= 1'b0;
						sclPhase <= 1'b1;
					end
					else if (tick)
					begin
						sclPhase <= 1'b0;
						state    <= (error && !rdFlag && (count != '0)) ? sDrain : sIdle;
					end
				end
				sDrain:
					// Discard data words left from the failed frame
					if (drainPop)
						count <= count - byteT'(1);
					else
						state <= sIdle;
				default:
					state <= sIdle;
			endcase
		end
	end

	// Data line is stable while the clock line is high, START and STOP aside
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		($changed(sdaOe) && (state != sStart) && !(state == sStop && sclPhase)) |-> !sclIn);

endmodule

`default_nettype wire

// File: verilog/syncFifo.sv
/* Single clock FIFO of 32-bit words. Head word is visible without a pop,
   a push when full or a pop when empty is ignored */
`default_nettype none
`timescale 1ns/10ps

module syncFifo (
	input  wire                                  PCLK,
	input  wire                                  PRESETn,
	input  wire                                  push,
	input  wire  [i2cFramePkg::wordWidth-1:0]    pushData,
	input  wire                                  pop,
	output logic [i2cFramePkg::wordWidth-1:0]    popData,
	output logic                                 full,
	output logic                                 empty
);

	// Pointers carry one extra wrap bit
	typedef logic [i2cFramePkg::fifoAddrWidth:0] ptrT;

	logic [i2cFramePkg::wordWidth-1:0] mem [i2cFramePkg::fifoDepth];
	ptrT                               wrPtr;
	ptrT                               rdPtr;

	// Same index, different wrap bit means full
	assign full  = (wrPtr[i2cFramePkg::fifoAddrWidth] != rdPtr[i2cFramePkg::fifoAddrWidth])
		&& (wrPtr[i2cFramePkg::fifoAddrWidth-1:0] == rdPtr[i2cFramePkg::fifoAddrWidth-1:0]);
	assign empty = (wrPtr == rdPtr);

	// Head of queue
	assign popData = mem[rdPtr[i2cFramePkg::fifoAddrWidth-1:0]];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (push && !full)
			mem[wrPtr[i2cFramePkg::fifoAddrWidth-1:0]] <= pushData;
	end

	// Pointers
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (push && !full)
				wrPtr <= wrPtr + ptrT'(1);
			if (pop && !empty)
				rdPtr <= rdPtr + ptrT'(1);
		end
	end

	// Both users must respect the flags
	assert property (@(posedge PCLK) disable iff (!PRESETn) push |-> !full);
	assert property (@(posedge PCLK) disable iff (!PRESETn) pop |-> !empty);

endmodule

`default_nettype wire
